//--- filelist.f
+incdir+hw
hw/hififo_pkg.sv
hw/completion_decode.sv
hw/descriptor_fetch.sv
hw/reorder_buffer.sv
hw/output_fifo.sv
hw/from_pc_fifo.sv
tb/from_pc_fifo_chk.sv
tb/from_pc_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the streaming engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module from_pc_fifo_tb -f filelist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1

//--- tb/from_pc_fifo_tb.sv
// testbench for the host to card streaming engine, channel 2
// host memory model answers descriptor and block reads, returns block words
// interleaved out of order and adds completions for channel 5;
// a descriptor table runs in a loop and the FIFO output is checked word by word
`timescale 1ns/100ps
`include "hififo_settings.svh"

module from_pc_fifo_tb;
   localparam int CHANNEL      = 2;
   localparam int OTHER_CHAN   = 5;
   localparam int BLOCK_WORDS  = 1 << `HIFIFO_BLOCK_WORDS_LOG2;
   localparam int BLOCK_BYTES  = 8 * BLOCK_WORDS;
   localparam int NUM_TESTS    = 5;
   localparam int STALL_CYCLES = 400;

   typedef struct packed {
      logic [63:0] desc_addr;
      logic [47:0] data_addr;  // 512-byte aligned
      logic [15:0] blocks;
      logic        stall;      // reading held off at first
   } test_row_t;

   // descriptor address, data address, block count, stalled reading
   test_row_t tests [NUM_TESTS] = '{
      '{64'h0000_0000_0000_1000, 48'h0000_0010_0000, 16'd1, 1'b0},
      '{64'h0000_0000_0000_1040, 48'h0000_0020_0000, 16'd8, 1'b0},
      '{64'h0000_0000_0000_1080, 48'h0000_0030_0000, 16'd10, 1'b1},
      '{64'h0000_0000_0000_10c0, 48'h0000_0040_0200, 16'd13, 1'b0},
      '{64'h0000_0000_0000_1100, 48'habcd_0000_0000, 16'd3, 1'b1}
   };
   string names [NUM_TESTS] = '{"one_block", "eight_blocks", "stalled_read",
                                "slot_wrap", "high_addr"};

   logic                                clock = 1'b0;
   logic                                reset;
   logic                                i_pio_wvalid;
   logic [63:0]                         i_pio_wdata;
   logic                                i_rc_valid;
   hififo_pkg::rc_tag_t                 i_rc_tag;
   logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] i_rc_index;
   hififo_pkg::fifo_word_t              i_rc_data;
   logic                                o_rr0_valid;
   logic [63:0]                         o_rr0_addr;
   logic                                i_rr0_ready;
   logic                                o_rr1_valid;
   logic [63:0]                         o_rr1_addr;
   logic [`HIFIFO_SLOTS_LOG2-1:0]       o_rr1_tag;
   logic                                i_rr1_ready;
   logic                                i_fifo_read;
   hififo_pkg::fifo_word_t              o_fifo_data;
   logic                                o_fifo_valid;
   logic [31:0]                         o_status;
   logic                                o_interrupt;

   logic [15:0] lfsr = 16'd52;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic        host_on = 1'b0;
   logic        read_enable = 1'b0;
   string       cur_name = "reset_state";
   logic [63:0] cur_desc_addr = '0;
   logic [63:0] cur_data_addr = '0;
   logic [15:0] cur_blocks = '0;
   int          words_got = 0;
   int          irq_count = 0;
   int          req_total = 0;  // tag source across descriptors
   int          req_in_desc = 0;
   int          desc_delay = 0;
   logic [63:0] pend_addr [$];  // blocks requested with words still owed
   logic [2:0]  pend_slot [$];
   int          pend_word [$];

   always #4 clock = ~clock;

   from_pc_fifo #(.FIFO_NUMBER(CHANNEL)) dut (.*);

   bind from_pc_fifo from_pc_fifo_chk chk (
      .clock           (clock),
      .reset           (reset),
      .i_rr0_valid     (o_rr0_valid),
      .i_rr0_addr      (o_rr0_addr),
      .i_rr0_ready     (i_rr0_ready),
      .i_rr1_valid     (o_rr1_valid),
      .i_rr1_addr      (o_rr1_addr),
      .i_rr1_tag       (o_rr1_tag),
      .i_rr1_ready     (i_rr1_ready),
      .i_block_drained (block_drained),
      .i_fifo_valid    (o_fifo_valid),
      .i_fifo_read     (i_fifo_read)
   );

   function automatic logic [15:0] galois_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         value = (value << 1) | int'(lfsr[0]);
         lfsr  = galois_step(lfsr);
      end
   endtask

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("ERR %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int err_mark, input int words);
      int errs;
      errs = errors - err_mark;
      tests_run++;
      if (errs != 0)
         tests_failed++;
      $display("test %s: %s, %0d words, %0d mismatches", name,
               (errs == 0) ? "ok" : "FAILED", words, errs);
   endtask

   task automatic send_completion(input logic [7:0] tag, input logic [5:0] index,
                                  input logic [63:0] data);
      i_rc_valid = 1'b1;
      i_rc_tag   = tag;
      i_rc_index = index;
      i_rc_data  = data;
   endtask

   task automatic write_pio(input logic [63:0] addr);
      @(negedge clock);
      i_pio_wvalid = 1'b1;
      i_pio_wdata  = addr;
      @(negedge clock);
      i_pio_wvalid = 1'b0;
   endtask

   task automatic run_row(input int r);
      int          err_mark;
      int          expected_words;
      int          got;
      int          irqs;
      int          reqs;
      logic [31:0] status_start;
      @(posedge clock);
      cur_name       = names[r];
      cur_desc_addr  = tests[r].desc_addr;
      cur_data_addr  = 64'(tests[r].data_addr);
      cur_blocks     = tests[r].blocks;
      words_got      = 0;
      irq_count      = 0;
      req_in_desc    = 0;
      read_enable    = !tests[r].stall;
      err_mark       = errors;
      expected_words = int'(tests[r].blocks) * BLOCK_WORDS;
      @(negedge clock);
      status_start = o_status;
      write_pio(tests[r].desc_addr);
      if (tests[r].stall) begin
         repeat (100) @(negedge clock);
         write_pio(64'hbad0_0000); // lands mid descriptor
         repeat (STALL_CYCLES) @(posedge clock);
         read_enable = 1'b1;
      end
      while (words_got < expected_words || irq_count == 0)
         @(posedge clock);
      repeat (40) @(posedge clock); // room for stray words or pulses
      got  = words_got;
      irqs = irq_count;
      reqs = req_in_desc;
      @(negedge clock);
      check_value({cur_name, " word count"}, 64'(expected_words), 64'(got));
      check_value({cur_name, " interrupts"}, 64'd1, 64'(irqs));
      check_value({cur_name, " block requests"}, 64'(tests[r].blocks), 64'(reqs));
      check_value({cur_name, " status"}, 64'(status_start + 32'(tests[r].blocks)),
                  64'(o_status));
      check_value({cur_name, " fifo valid"}, 64'd0, 64'(o_fifo_valid));
      report_test(cur_name, err_mark, got);
   endtask

   initial begin : main_sequence
      int          err_mark;
      logic [31:0] status_before;
      reset        = 1'b1;
      i_pio_wvalid = 1'b0;
      i_pio_wdata  = '0;
      repeat (16) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      @(negedge clock);
      check_value("reset_state rr0 valid", 64'd0, 64'(o_rr0_valid));
      check_value("reset_state rr1 valid", 64'd0, 64'(o_rr1_valid));
      check_value("reset_state fifo valid", 64'd0, 64'(o_fifo_valid));
      check_value("reset_state interrupt", 64'd0, 64'(o_interrupt));
      check_value("reset_state status", 64'd0, 64'(o_status));
      report_test("reset_state", 0, 0);
      @(posedge clock);
      host_on = 1'b1;
      for (int r = 0; r < NUM_TESTS; r++)
         run_row(r);

      // idle with only channel 5 completions arriving
      @(posedge clock);
      cur_name    = "other_channel";
      read_enable = 1'b0; // a leaked word would sit on the output
      err_mark    = errors;
      @(negedge clock);
      status_before = o_status;
      repeat (300) @(negedge clock);
      check_value("other_channel status", 64'(status_before), 64'(o_status));
      check_value("other_channel fifo valid", 64'd0, 64'(o_fifo_valid));
      check_value("other_channel rr0 valid", 64'd0, 64'(o_rr0_valid));
      check_value("other_channel rr1 valid", 64'd0, 64'(o_rr1_valid));
      report_test("other_channel", err_mark, 0);

      $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // host memory model sampling and driving on the falling edge
   initial begin : host_model
      int idx;
      int v;
      i_rr0_ready = 1'b0;
      i_rr1_ready = 1'b0;
      i_fifo_read = 1'b0;
      i_rc_valid  = 1'b0;
      i_rc_tag    = '0;
      i_rc_index  = '0;
      i_rc_data   = '0;
      forever begin
         @(negedge clock);
         i_rc_valid = 1'b0;
         if (host_on) begin
            if (desc_delay > 0) begin
               desc_delay--;
               if (desc_delay == 0)
                  send_completion({1'b1, 4'b0, 3'(CHANNEL)}, 6'd0,
                                  {cur_data_addr[47:0], cur_blocks});
               else // channel 5 descriptor while ours is awaited
                  send_completion({1'b1, 4'b0, 3'(OTHER_CHAN)}, 6'd0,
                                  64'hdead_0000_0000_0005);
            end else begin
               take_bits(2, v);
               if (pend_addr.size() > 0 && v != 0) begin
                  take_bits(3, v);
                  idx = v % pend_addr.size(); // any owed block with its words in order
                  send_completion({4'(CHANNEL), 1'b0, pend_slot[idx]}, 6'(pend_word[idx]),
                                  pend_addr[idx] + 64'(8 * pend_word[idx]));
                  pend_word[idx] = pend_word[idx] + 1;
                  if (pend_word[idx] == BLOCK_WORDS) begin
                     pend_addr.delete(idx);
                     pend_slot.delete(idx);
                     pend_word.delete(idx);
                  end
               end else begin
                  take_bits(6, v);
                  if (v[5:4] == 2'b00) // noise for channel 5
                     send_completion(v[3] ? {1'b1, 4'b0, 3'(OTHER_CHAN)} :
                                     {4'(OTHER_CHAN), 1'b0, 3'(v)},
                                     v[2] ? 6'd63 : 6'd0, 64'hdead_0000_0000_0000 | 64'(v));
               end
            end

            take_bits(1, v);
            i_rr0_ready = v[0];
            if (o_rr0_valid && i_rr0_ready) begin
               check_value({cur_name, " desc addr"}, cur_desc_addr, o_rr0_addr);
               take_bits(2, v);
               desc_delay = 2 + v;
            end
            take_bits(2, v);
            i_rr1_ready = (v != 0);
            if (o_rr1_valid && i_rr1_ready) begin
               check_value({cur_name, " rr1 tag"}, 64'(req_total % 8), 64'(o_rr1_tag));
               check_value({cur_name, " rr1 addr"},
                           cur_data_addr + 64'(req_in_desc) * 64'(BLOCK_BYTES), o_rr1_addr);
               pend_addr.push_back(o_rr1_addr);
               pend_slot.push_back(o_rr1_tag);
               pend_word.push_back(0);
               req_total++;
               req_in_desc++;
            end

            take_bits(2, v);
            i_fifo_read = read_enable && (v != 0);
            if (o_fifo_valid && i_fifo_read) begin
               check_value($sformatf("%s word %0d", cur_name, words_got),
                           cur_data_addr + 64'(8 * words_got), o_fifo_data);
               words_got++;
            end
            if (o_interrupt)
               irq_count++;
         end
      end
   end

   initial begin : watchdog
      int limit;
      limit = 3000;
      for (int r = 0; r < NUM_TESTS; r++)
         limit += int'(tests[r].blocks) * BLOCK_WORDS * 20 + STALL_CYCLES;
      repeat (limit) @(posedge clock);
      $display("watchdog: run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- tb/from_pc_fifo_chk.sv
// request and FIFO rule checks, bound into the streaming engine top level
// requests hold until ready, data requests stay under the outstanding
// limit, FIFO valid only falls after a read
`timescale 1ns/100ps
`include "hififo_settings.svh"

module from_pc_fifo_chk (
   input logic        clock,
   input logic        reset,
   input logic        i_rr0_valid,
   input logic [63:0] i_rr0_addr,
   input logic        i_rr0_ready,
   input logic        i_rr1_valid,
   input logic [63:0] i_rr1_addr,
   input logic [2:0]  i_rr1_tag,
   input logic        i_rr1_ready,
   input logic        i_block_drained,
   input logic        i_fifo_valid,
   input logic        i_fifo_read
);
   logic [3:0] in_flight; // accepted data requests not yet drained

   always_ff @(posedge clock) begin
      if (reset)
         in_flight <= '0;
      else
         in_flight <= in_flight + 4'(i_rr1_valid && i_rr1_ready) - 4'(i_block_drained);
   end

   rr0_hold: assert property (@(posedge clock) disable iff (reset)
      (i_rr0_valid && !i_rr0_ready) |=> (i_rr0_valid && $stable(i_rr0_addr)))
      else $error("descriptor request dropped or changed before ready");

   rr1_hold: assert property (@(posedge clock) disable iff (reset)
      (i_rr1_valid && !i_rr1_ready) |=>
         (i_rr1_valid && $stable(i_rr1_addr) && $stable(i_rr1_tag)))
      else $error("data request dropped or changed before ready");

   outstanding_limit: assert property (@(posedge clock) disable iff (reset)
      in_flight <= 4'(`HIFIFO_MAX_OUTSTANDING))
      else $error("more data requests outstanding than allowed");

   fifo_valid_hold: assert property (@(posedge clock) disable iff (reset)
      (i_fifo_valid && !i_fifo_read) |=> i_fifo_valid)
      else $error("fifo valid fell without a read");

endmodule

//--- hw/from_pc_fifo.sv
// host to card streaming engine, one channel
// completion decode feeds descriptor fetch and the reorder buffer,
// which drains in order into a first-word-fall-through output FIFO
`timescale 1ns/100ps
`include "hififo_settings.svh"

module from_pc_fifo #(
   parameter int FIFO_NUMBER = 0
) (
   input  logic                                clock,
   input  logic                                reset,
   input  logic                                i_pio_wvalid,
   input  logic [63:0]                         i_pio_wdata,
   input  logic                                i_rc_valid,
   input  hififo_pkg::rc_tag_t                 i_rc_tag,
   input  logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] i_rc_index,
   input  hififo_pkg::fifo_word_t              i_rc_data,
   output logic                                o_rr0_valid,
   output logic [63:0]                         o_rr0_addr,
   input  logic                                i_rr0_ready,
   output logic                                o_rr1_valid,
   output logic [63:0]                         o_rr1_addr,
   output logic [`HIFIFO_SLOTS_LOG2-1:0]       o_rr1_tag,
   input  logic                                i_rr1_ready,
   input  logic                                i_fifo_read,
   output hififo_pkg::fifo_word_t              o_fifo_data,
   output logic                                o_fifo_valid,
   output logic [31:0]                         o_status,
   output logic                                o_interrupt
);
   import hififo_pkg::*;

   logic                                desc_valid;
   fifo_word_t                          desc_word;
   logic                                ram_write;
   logic [`HIFIFO_SLOTS_LOG2-1:0]       ram_slot;
   logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] ram_index;
   fifo_word_t                          ram_data;
   logic                                ram_last;
   logic                                fifo_ready;
   logic                                fifo_write;
   fifo_word_t                          fifo_wdata;
   logic                                block_drained; // releases request credit

   completion_decode #(.FIFO_NUMBER(FIFO_NUMBER)) u_decode (
      .clock        (clock),
      .reset        (reset),
      .i_rc_valid   (i_rc_valid),
      .i_rc_tag     (i_rc_tag),
      .i_rc_index   (i_rc_index),
      .i_rc_data    (i_rc_data),
      .o_desc_valid (desc_valid),
      .o_desc_word  (desc_word),
      .o_ram_write  (ram_write),
      .o_ram_slot   (ram_slot),
      .o_ram_index  (ram_index),
      .o_ram_data   (ram_data),
      .o_ram_last   (ram_last)
   );

   descriptor_fetch u_fetch (
      .clock           (clock),
      .reset           (reset),
      .i_pio_wvalid    (i_pio_wvalid),
      .i_pio_wdata     (i_pio_wdata),
      .i_desc_valid    (desc_valid),
      .i_desc_word     (desc_word),
      .o_rr0_valid     (o_rr0_valid),
      .o_rr0_addr      (o_rr0_addr),
      .i_rr0_ready     (i_rr0_ready),
      .o_rr1_valid     (o_rr1_valid),
      .o_rr1_addr      (o_rr1_addr),
      .o_rr1_tag       (o_rr1_tag),
      .i_rr1_ready     (i_rr1_ready),
      .i_block_drained (block_drained),
      .o_interrupt     (o_interrupt)
   );

   reorder_buffer u_reorder (
      .clock           (clock),
      .reset           (reset),
      .i_ram_write     (ram_write),
      .i_ram_slot      (ram_slot),
      .i_ram_index     (ram_index),
      .i_ram_data      (ram_data),
      .i_ram_last      (ram_last),
      .i_fifo_ready    (fifo_ready),
      .o_fifo_write    (fifo_write),
      .o_fifo_data     (fifo_wdata),
      .o_block_drained (block_drained),
      .o_status        (o_status)
   );

   output_fifo u_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_write (fifo_write),
      .i_data  (fifo_wdata),
      .o_ready (fifo_ready),
      .i_read  (i_fifo_read),
      .o_data  (o_fifo_data),
      .o_valid (o_fifo_valid)
   );

endmodule

//--- hw/output_fifo.sv
// output FIFO, first word fall through
// circular buffer behind an output register; an empty FIFO passes the
// written word straight to the output register
`timescale 1ns/100ps
`include "hififo_settings.svh"

module output_fifo (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   i_write,
   input  hififo_pkg::fifo_word_t i_data,
   output logic                   o_ready,
   input  logic                   i_read,
   output hififo_pkg::fifo_word_t o_data,
   output logic                   o_valid
);
   import hififo_pkg::*;

   localparam int          AW          = `HIFIFO_FIFO_DEPTH_LOG2;
   localparam int          DEPTH       = 1 << AW;
   localparam logic [AW:0] READY_LIMIT = (AW + 1)'(DEPTH - 3);

   fifo_word_t  mem [0:DEPTH-1];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] used;
   logic        empty;
   logic        load;
   logic        bypass;
   logic        pop;
   logic        push;

   assign used   = wr_ptr - rd_ptr;
   assign empty  = (used == '0);
   assign load   = !o_valid || i_read; // output register free next cycle
   assign bypass = load && empty && i_write;
   assign pop    = load && !empty;
   assign push   = i_write && !bypass;

   // three free entries, two words may already be in flight
   assign o_ready = (used <= READY_LIMIT);

   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         o_valid <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (load)
            o_valid <= !empty || i_write;
      end
   end

   always_ff @(posedge clock) begin
      if (push)
         mem[wr_ptr[AW-1:0]] <= i_data;
      if (pop)
         o_data <= mem[rd_ptr[AW-1:0]];
      else if (bypass)
         o_data <= i_data;
   end

endmodule

//--- hw/reorder_buffer.sv
// reorder buffer
// completions land in a 512-word RAM at slot and word index; slots are
// marked full on word 63 and drained strictly in request order into the
// output FIFO over a two-cycle read path
`timescale 1ns/100ps
`include "hififo_settings.svh"

module reorder_buffer (
   input  logic                                clock,
   input  logic                                reset,
   input  logic                                i_ram_write,
   input  logic [`HIFIFO_SLOTS_LOG2-1:0]       i_ram_slot,
   input  logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] i_ram_index,
   input  hififo_pkg::fifo_word_t              i_ram_data,
   input  logic                                i_ram_last,
   input  logic                                i_fifo_ready,
   output logic                                o_fifo_write,
   output hififo_pkg::fifo_word_t              o_fifo_data,
   output logic                                o_block_drained,
   output logic [31:0]                         o_status
);
   import hififo_pkg::*;

   localparam int SL        = `HIFIFO_SLOTS_LOG2;
   localparam int BW        = `HIFIFO_BLOCK_WORDS_LOG2;
   localparam int SLOTS     = 1 << SL;
   localparam int ADDR_BITS = SL + BW;

   fifo_word_t           ram [0:(1 << ADDR_BITS)-1];
   fifo_word_t           rd_word;
   logic [SLOTS-1:0]     filled;   // per-slot fill flags
   logic [SL-1:0]        p_write;  // first slot not yet known full
   logic [ADDR_BITS-1:0] p_read;   // slot and word being drained
   logic [SL-1:0]        rd_slot;
   logic                 rd_en;
   logic                 rd_last;
   logic                 rd_valid;

   assign rd_slot = p_read[ADDR_BITS-1 -: SL];
   assign rd_en   = (rd_slot != p_write) && i_fifo_ready; // only slots behind p_write
   assign rd_last = rd_en && (&p_read[BW-1:0]);

   always_ff @(posedge clock) begin
      if (reset) begin
         filled          <= '0;
         p_write         <= '0;
         p_read          <= '0;
         rd_valid        <= 1'b0;
         o_fifo_write    <= 1'b0;
         o_block_drained <= 1'b0;
         o_status        <= '0;
      end else begin
         if (filled[p_write])
            p_write <= p_write + 1'b1;
         if (rd_en)
            p_read <= p_read + 1'b1;
         rd_valid        <= rd_en;
         o_fifo_write    <= rd_valid; // two cycles behind the read
         o_block_drained <= rd_last;
         if (rd_last)
            o_status <= o_status + 1'b1;
         for (int s = 0; s < SLOTS; s++) begin
            if (i_ram_write && i_ram_last && (i_ram_slot == SL'(s)))
               filled[s] <= 1'b1;
            else if (rd_last && (rd_slot == SL'(s)))
               filled[s] <= 1'b0;
         end
      end
   end

   // RAM and read pipeline
   always_ff @(posedge clock) begin
      if (i_ram_write)
         ram[{i_ram_slot, i_ram_index}] <= i_ram_data;
      if (rd_en)
         rd_word <= ram[p_read];
      o_fifo_data <= rd_word;
   end

endmodule

//--- hw/descriptor_fetch.sv
// descriptor fetch and data request engine
// a PIO write gives the descriptor address, the descriptor read returns
// data address and block count, then tagged block requests go out under
// an outstanding limit and a holdoff; interrupt when the last block drains
`timescale 1ns/100ps
`include "hififo_settings.svh"

module descriptor_fetch (
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          i_pio_wvalid,
   input  logic [63:0]                   i_pio_wdata,
   input  logic                          i_desc_valid,
   input  hififo_pkg::fifo_word_t        i_desc_word,
   output logic                          o_rr0_valid,
   output logic [63:0]                   o_rr0_addr,
   input  logic                          i_rr0_ready,
   output logic                          o_rr1_valid,
   output logic [63:0]                   o_rr1_addr,
   output logic [`HIFIFO_SLOTS_LOG2-1:0] o_rr1_tag,
   input  logic                          i_rr1_ready,
   input  logic                          i_block_drained,
   output logic                          o_interrupt
);
   localparam logic [1:0] ST_IDLE      = 2'd0;
   localparam logic [1:0] ST_DESC_REQ  = 2'd1;
   localparam logic [1:0] ST_DESC_WAIT = 2'd2;
   localparam logic [1:0] ST_DATA      = 2'd3;
   localparam int         BLOCK_BYTES  = 8 << `HIFIFO_BLOCK_WORDS_LOG2;
   localparam int         HOLD_BITS    = $clog2(`HIFIFO_HOLDOFF + 1);
   localparam logic [3:0] MAX_OUT      = `HIFIFO_MAX_OUTSTANDING;

   logic [1:0]                   state;
   logic [15:0]                  req_left;    // blocks still to request
   logic [15:0]                  drain_left;  // blocks still to drain
   logic [3:0]                   outstanding;
   logic [HOLD_BITS-1:0]         holdoff;
   logic [`HIFIFO_SLOTS_LOG2-1:0] req_count;
   logic                         rr1_accept;
   logic                         req_ok;
   logic [15:0]                  desc_count;

   assign rr1_accept = o_rr1_valid && i_rr1_ready;
   assign req_ok     = (outstanding < MAX_OUT) && (holdoff == '0) && !rr1_accept;
   assign desc_count = i_desc_word[15:0];
   assign o_rr1_tag  = req_count; // slot = request count mod 8

   always_ff @(posedge clock) begin
      if (reset) begin
         state       <= ST_IDLE;
         o_rr0_valid <= 1'b0;
         o_rr1_valid <= 1'b0;
         o_interrupt <= 1'b0;
         req_left    <= '0;
         drain_left  <= '0;
         outstanding <= '0;
         holdoff     <= '0;
         req_count   <= '0;
      end else begin
         o_interrupt <= 1'b0;
         if (rr1_accept) begin
            holdoff   <= HOLD_BITS'(`HIFIFO_HOLDOFF);
            req_count <= req_count + 1'b1;
            req_left  <= req_left - 1'b1;
         end else if (holdoff != '0) begin
            holdoff <= holdoff - 1'b1;
         end
         outstanding <= outstanding + {3'b0, rr1_accept} - {3'b0, i_block_drained};

         case (state)
            ST_IDLE: begin
               if (i_pio_wvalid) begin
                  state       <= ST_DESC_REQ;
                  o_rr0_valid <= 1'b1;
               end
            end
            ST_DESC_REQ: begin
               if (i_rr0_ready) begin
                  o_rr0_valid <= 1'b0;
                  state       <= ST_DESC_WAIT;
               end
            end
            ST_DESC_WAIT: begin
               if (i_desc_valid) begin
                  req_left   <= desc_count;
                  drain_left <= desc_count;
                  if (desc_count == '0) begin // empty descriptor, done at once
                     state       <= ST_IDLE;
                     o_interrupt <= 1'b1;
                  end else begin
                     state       <= ST_DATA;
                     o_rr1_valid <= req_ok;
                  end
               end
            end
            default: begin
               o_rr1_valid <= (req_left != '0) && req_ok;
               if (i_block_drained) begin
                  drain_left <= drain_left - 1'b1;
                  if (drain_left == 16'd1) begin
                     state       <= ST_IDLE;
                     o_interrupt <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // request addresses
   always_ff @(posedge clock) begin
      if (state == ST_IDLE && i_pio_wvalid)
         o_rr0_addr <= i_pio_wdata;
      if (state == ST_DESC_WAIT && i_desc_valid)
         o_rr1_addr <= {16'h0, i_desc_word[63:16]}; // byte address from bits 63:16
      else if (rr1_accept)
         o_rr1_addr <= o_rr1_addr + 64'(BLOCK_BYTES);
   end

endmodule

//--- hw/completion_decode.sv
// completion decode
// splits incoming read completions for this channel into a descriptor word
// strobe or a reorder RAM write, one register stage
`timescale 1ns/100ps
`include "hififo_settings.svh"

module completion_decode #(
   parameter int FIFO_NUMBER = 0
) (
   input  logic                                clock,
   input  logic                                reset,
   input  logic                                i_rc_valid,
   input  hififo_pkg::rc_tag_t                 i_rc_tag,
   input  logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] i_rc_index,
   input  hififo_pkg::fifo_word_t              i_rc_data,
   output logic                                o_desc_valid,
   output hififo_pkg::fifo_word_t              o_desc_word,
   output logic                                o_ram_write,
   output logic [`HIFIFO_SLOTS_LOG2-1:0]       o_ram_slot,
   output logic [`HIFIFO_BLOCK_WORDS_LOG2-1:0] o_ram_index,
   output hififo_pkg::fifo_word_t              o_ram_data,
   output logic                                o_ram_last
);
   import hififo_pkg::*;

   fifo_word_t data_q;
   logic       is_desc;
   logic       is_data;

   // descriptor view, one word at index 0
   assign is_desc = i_rc_valid && i_rc_tag.desc.is_desc &&
                    (i_rc_tag.desc.channel == 3'(FIFO_NUMBER)) && (i_rc_index == '0);
   // data view, whole upper nibble names the channel
   assign is_data = i_rc_valid && (i_rc_tag.data.channel == 4'(FIFO_NUMBER));

   always_ff @(posedge clock) begin
      if (reset) begin
         o_desc_valid <= 1'b0;
         o_ram_write  <= 1'b0;
      end else begin
         o_desc_valid <= is_desc;
         o_ram_write  <= is_data;
      end
   end

   always_ff @(posedge clock) begin
      data_q      <= i_rc_data;
      o_ram_slot  <= i_rc_tag.data.slot[`HIFIFO_SLOTS_LOG2-1:0];
      o_ram_index <= i_rc_index;
      o_ram_last  <= is_data && (&i_rc_index); // word 63 closes the block
   end

   assign o_desc_word = data_q;
   assign o_ram_data  = data_q;

endmodule

//--- hw/hififo_pkg.sv
// hififo shared types
// the completion tag is read two ways, as a data tag or a descriptor tag,
// so it is carried as a packed union over both views
package hififo_pkg;

   typedef logic [63:0] fifo_word_t;

   // data completion: channel above, reorder slot below
   typedef struct packed {
      logic [3:0] channel;
      logic [3:0] slot;
   } rc_tag_data_t;

   // descriptor completion
   typedef struct packed {
      logic       is_desc;  // set for descriptor reads
      logic [3:0] reserved;
      logic [2:0] channel;
   } rc_tag_desc_t;

   typedef union packed {
      rc_tag_data_t data;
      rc_tag_desc_t desc;
   } rc_tag_t;

endpackage

//--- hw/hififo_settings.svh
// hififo streaming engine settings
// block geometry, reorder slots, request limits and output FIFO depth
`ifndef HIFIFO_SETTINGS_SVH
`define HIFIFO_SETTINGS_SVH

`define HIFIFO_BLOCK_WORDS_LOG2 6 // 64 words of 64 bits, 512 bytes

`define HIFIFO_SLOTS_LOG2 3 // eight reorder slots

`define HIFIFO_MAX_OUTSTANDING 6 // blocks requested and not yet drained

`define HIFIFO_FIFO_DEPTH_LOG2 4

`define HIFIFO_HOLDOFF 3 // idle cycles after an accepted data request

`endif
